/* design/cmd_mem.sv */
`timescale 1ns/10ps

module cmd_mem import cmd_pkg::*; #(
    parameter int DEPTH = MEM_DEPTH
) (
    input  logic      BUS_CLK,
    input  logic      en,
    input  logic      we,
    input  mem_addr_t addr,
    input  cmd_byte_t wdata,
    output cmd_byte_t rdata,
    input  mem_addr_t rd_addr,
    output cmd_byte_t rd_data
);

    cmd_byte_t mem [DEPTH];

    // Bus port, read before write
    always_ff @(posedge BUS_CLK) begin
        if (en) begin
            if (we)
                mem[addr] <= wdata;
            rdata <= mem[addr];
        end
    end

    // Sequencer port reads every cycle
    always_ff @(posedge BUS_CLK) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* design/cmd_pkg.sv */
package cmd_pkg;

    // Bus and memory geometry
    typedef logic [7:0]  cmd_byte_t;
    typedef logic [15:0] bus_addr_t;

    localparam int          MEM_ADDR_W = 10;
    localparam int unsigned MEM_DEPTH  = 2 ** MEM_ADDR_W;

    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

    localparam cmd_byte_t   VERSION      = 8'd1;
    localparam bus_addr_t   REG_COUNT    = 16'd16;   // Memory starts right after
    localparam logic [15:0] SYNC_PATTERN = 16'h817E; // Low byte goes out first

    // Register map
    localparam bus_addr_t ADDR_RESET    = 16'd0;  // Write gives soft reset
    localparam bus_addr_t ADDR_START    = 16'd1;  // Write starts, read gives status
    localparam bus_addr_t ADDR_SIZE_LO  = 16'd3;
    localparam bus_addr_t ADDR_SIZE_HI  = 16'd4;
    localparam bus_addr_t ADDR_REP_LO   = 16'd5;
    localparam bus_addr_t ADDR_REP_HI   = 16'd6;
    localparam bus_addr_t ADDR_MEMSZ_LO = 16'd7;  // Read only
    localparam bus_addr_t ADDR_MEMSZ_HI = 16'd8;

    // Sequencer states
    typedef enum logic [1:0] {
        INIT,
        DATA,
        SYNC
    } seq_state_t;

endpackage

/* design/cmd_regs.sv */
`timescale 1ns/10ps

module cmd_regs import cmd_pkg::*; (
    input  logic        BUS_CLK,
    input  logic        RST,
    input  bus_addr_t   bus_add,
    input  cmd_byte_t   bus_data_in,
    input  logic        bus_rd,
    input  logic        bus_wr,
    input  cmd_byte_t   mem_rdata,
    input  logic        done,
    input  logic        syncing,
    output cmd_byte_t   bus_data_out,
    output logic        soft_rst,
    output logic        start,
    output logic [15:0] conf_size,
    output logic [15:0] conf_repeat,
    output logic        mem_we,
    output logic        mem_en,
    output mem_addr_t   mem_addr
);

    cmd_byte_t regs [REG_COUNT];
    cmd_byte_t rd_byte;     // Register value for the pending read
    bus_addr_t prev_add;    // Address of last cycle's read or zero
    logic      reg_sel;
    logic      regs_rst;

    assign reg_sel  = (bus_add < REG_COUNT);
    assign soft_rst = bus_wr && (bus_add == ADDR_RESET);
    assign start    = bus_wr && (bus_add == ADDR_START);
    assign regs_rst = RST || soft_rst;

    assign conf_size   = {regs[ADDR_SIZE_HI[3:0]], regs[ADDR_SIZE_LO[3:0]]};
    assign conf_repeat = {regs[ADDR_REP_HI[3:0]], regs[ADDR_REP_LO[3:0]]};

    always_ff @(posedge BUS_CLK) begin
        if (regs_rst) begin
            regs                    <= '{default: 8'd0};
            regs[ADDR_REP_LO[3:0]]  <= 8'd1;  // Send once by default
        end else if (bus_wr && reg_sel) begin
            regs[bus_add[3:0]] <= bus_data_in;
        end
    end

    // Read data is registered and valid in the cycle after bus_rd
    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            rd_byte  <= '0;
            prev_add <= '0;
        end else begin
            prev_add <= bus_rd ? bus_add : '0;
            if (!bus_rd || !reg_sel) begin
                rd_byte <= '0;
            end else begin
                case (bus_add)
                    ADDR_RESET:    rd_byte <= VERSION;
                    ADDR_START:    rd_byte <= {6'd0, syncing, done};
                    ADDR_MEMSZ_LO: rd_byte <= 8'(MEM_DEPTH);
                    ADDR_MEMSZ_HI: rd_byte <= 8'(MEM_DEPTH >> 8);
                    default:       rd_byte <= regs[bus_add[3:0]];
                endcase
            end
        end
    end

    assign bus_data_out = (prev_add >= REG_COUNT) ? mem_rdata : rd_byte;

    // Memory window above the register range
    assign mem_en   = (bus_rd || bus_wr) && !reg_sel;
    assign mem_we   = bus_wr && !reg_sel;
    assign mem_addr = mem_addr_t'(bus_add - REG_COUNT);

    assert property (@(posedge BUS_CLK) disable iff (RST)
        !$past(bus_rd) |-> bus_data_out == 8'd0)
        else $error("Read data present without a read in the previous cycle");

endmodule

/* design/cmd_sequencer.sv */
`timescale 1ns/10ps

module cmd_sequencer import cmd_pkg::*; (
    input  logic        BUS_CLK,
    input  logic        RST,
    input  logic        start,
    input  logic [15:0] conf_size,
    input  logic [15:0] conf_repeat,
    input  logic        byte_pulse,
    input  cmd_byte_t   rd_data,
    output mem_addr_t   rd_addr,
    output cmd_byte_t   next_byte,
    output logic        serial_en,
    output logic        done,
    output logic        syncing
);

    seq_state_t  state;
    logic [15:0] rep_cnt;     // Passes already sent in this run
    logic [15:0] last_rep;
    logic        last_byte;
    logic        go;          // Start with a usable length
    logic        start_pend;  // Start waiting for a byte boundary
    logic        sync_hi;     // Next sync byte is 0x81

    assign go        = start && (conf_size != 16'd0);
    assign last_rep  = (conf_repeat == 16'd0) ? 16'd0 : conf_repeat - 16'd1;
    assign last_byte = (16'(rd_addr) == conf_size - 16'd1);

    assign next_byte = (state == DATA) ? rd_data :
                       (sync_hi ? SYNC_PATTERN[15:8] : SYNC_PATTERN[7:0]);
    assign syncing   = (state == SYNC);

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            state      <= INIT;
            rd_addr    <= '0;
            rep_cnt    <= '0;
            serial_en  <= 1'b0;
            done       <= 1'b1;
            start_pend <= 1'b0;
            sync_hi    <= 1'b0;
        end else begin
            case (state)
                INIT: begin
                    // rd_addr sits at 0, so byte 0 is already on rd_data
                    if (go) begin
                        state     <= DATA;
                        rep_cnt   <= '0;
                        serial_en <= 1'b1;
                        done      <= 1'b0;
                    end
                end
                DATA: begin
                    if (byte_pulse) begin
                        if (last_byte) begin
                            rd_addr <= '0;
                            if (rep_cnt == last_rep) begin
                                state   <= SYNC;
                                sync_hi <= 1'b0;  // Pair starts with 0x7E
                                done    <= 1'b1;
                            end else begin
                                rep_cnt <= rep_cnt + 16'd1;
                            end
                        end else begin
                            rd_addr <= rd_addr + 1'b1;
                        end
                    end
                end
                SYNC: begin
                    if (byte_pulse && (start_pend || go)) begin
                        state      <= DATA;
                        rep_cnt    <= '0;
                        start_pend <= 1'b0;
                        done       <= 1'b0;
                    end else begin
                        if (go)
                            start_pend <= 1'b1;
                        if (byte_pulse)
                            sync_hi <= !sync_hi;
                    end
                end
                default: state <= INIT;
            endcase
        end
    end

    assert property (@(posedge BUS_CLK) disable iff (RST)
        state == DATA |-> 16'(rd_addr) < conf_size)
        else $error("Sequencer address beyond sequence length");

    assert property (@(posedge BUS_CLK) disable iff (RST)
        state == INIT |-> !byte_pulse)
        else $error("Byte boundary from the serializer while idle");

endmodule

/* design/cmd_serializer.sv */
`timescale 1ns/10ps

module cmd_serializer import cmd_pkg::*; (
    input  logic      BUS_CLK,
    input  logic      RST,
    input  logic      serial_en,
    input  cmd_byte_t next_byte,
    output logic      byte_pulse,
    output logic      cmd_serial_out,
    output cmd_byte_t cmd_data_out
);

    logic [2:0] bit_cnt;
    cmd_byte_t  shift_reg;

    // Load happens on the counter wrap
    assign byte_pulse = serial_en && (bit_cnt == 3'd0);

    always_ff @(posedge BUS_CLK) begin
        if (RST || !serial_en) begin
            bit_cnt        <= '0;
            shift_reg      <= '0;
            cmd_serial_out <= 1'b0;
            cmd_data_out   <= '0;
        end else begin
            bit_cnt        <= bit_cnt + 3'd1;
            cmd_serial_out <= shift_reg[0];  // LSB first
            if (byte_pulse)
                shift_reg <= next_byte;
            else
                shift_reg <= {1'b0, shift_reg[7:1]};
            // Update together with the byte's first bit on the line
            if (bit_cnt == 3'd1)
                cmd_data_out <= shift_reg;
        end
    end

    assert property (@(posedge BUS_CLK) disable iff (RST)
        byte_pulse |-> !$past(serial_en) || $past(bit_cnt) == 3'd7)
        else $error("Byte load outside counter wrap");

endmodule

/* design/cmd_top.sv */
`timescale 1ns/10ps

module cmd_top import cmd_pkg::*; (
    input  logic      BUS_CLK,
    input  logic      RST,
    input  bus_addr_t bus_add,
    input  cmd_byte_t bus_data_in,
    input  logic      bus_rd,
    input  logic      bus_wr,
    output cmd_byte_t bus_data_out,
    output logic      cmd_serial_out,
    output cmd_byte_t cmd_data_out
);

    logic        soft_rst;
    logic        start;
    logic        core_rst;    // Encoder reset, hard or soft
    logic [15:0] conf_size;
    logic [15:0] conf_repeat;
    logic        mem_we;
    logic        mem_en;
    mem_addr_t   mem_addr;
    cmd_byte_t   mem_rdata;
    mem_addr_t   rd_addr;
    cmd_byte_t   rd_data;
    cmd_byte_t   next_byte;
    logic        serial_en;
    logic        byte_pulse;
    logic        done;
    logic        syncing;

    assign core_rst = RST || soft_rst;

    cmd_regs i_regs (
        .BUS_CLK(BUS_CLK), .RST(RST),
        .bus_add(bus_add), .bus_data_in(bus_data_in),
        .bus_rd(bus_rd), .bus_wr(bus_wr),
        .mem_rdata(mem_rdata), .done(done), .syncing(syncing),
        .bus_data_out(bus_data_out), .soft_rst(soft_rst), .start(start),
        .conf_size(conf_size), .conf_repeat(conf_repeat),
        .mem_we(mem_we), .mem_en(mem_en), .mem_addr(mem_addr)
    );

    cmd_mem #(.DEPTH(MEM_DEPTH)) i_mem (
        .BUS_CLK(BUS_CLK), .en(mem_en), .we(mem_we),
        .addr(mem_addr), .wdata(bus_data_in), .rdata(mem_rdata),
        .rd_addr(rd_addr), .rd_data(rd_data)
    );

    cmd_sequencer i_sequencer (
        .BUS_CLK(BUS_CLK), .RST(core_rst), .start(start),
        .conf_size(conf_size), .conf_repeat(conf_repeat),
        .byte_pulse(byte_pulse), .rd_data(rd_data), .rd_addr(rd_addr),
        .next_byte(next_byte), .serial_en(serial_en),
        .done(done), .syncing(syncing)
    );

    cmd_serializer i_serializer (
        .BUS_CLK(BUS_CLK), .RST(core_rst),
        .serial_en(serial_en), .next_byte(next_byte), .byte_pulse(byte_pulse),
        .cmd_serial_out(cmd_serial_out), .cmd_data_out(cmd_data_out)
    );

endmodule

/* flist.f */
design/cmd_pkg.sv
design/cmd_regs.sv
design/cmd_mem.sv
design/cmd_sequencer.sv
design/cmd_serializer.sv
design/cmd_top.sv
verif/tb_cmd_top.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the command encoder testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module tb_cmd_top -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test completed successfully" sim.log; then
    exit 0
fi
exit 1

/* verif/cmd_input.txt */
# op addr data, all hex: W bus write, R read with expected byte, Q soft reset
# S count: start, then check count serial bytes; W data ff into memory takes a random byte
R 0000 01
R 0001 01
R 0005 01
R 0003 00
R 0007 00
R 0008 04
W 000c a5
R 000c a5
W 0010 3c
R 0010 3c
W 0011 ff
W 0012 ff
W 0003 03
W 0005 02
R 0005 02
S 000a
Q
R 0005 01
R 000c 00
W 0010 ff
W 0011 ff
W 0003 02
W 0005 00
S 0006

/* verif/tb_cmd_top.sv */
`timescale 1ns/10ps

module tb_cmd_top import cmd_pkg::*; ();

    logic        BUS_CLK;
    logic        RST;
    bus_addr_t   bus_add;
    cmd_byte_t   bus_data_in;
    logic        bus_rd;
    logic        bus_wr;
    cmd_byte_t   bus_data_out;
    logic        cmd_serial_out;
    cmd_byte_t   cmd_data_out;

    cmd_byte_t   mirror [1024];      // Host copy of the command memory
    cmd_byte_t   shadow_regs [16];   // Host copy of the register bank
    integer      seed;
    int          byte_errors;
    int          bit_errors;
    int          other_errors;

    cmd_top UUT (
        .BUS_CLK(BUS_CLK), .RST(RST),
        .bus_add(bus_add), .bus_data_in(bus_data_in),
        .bus_rd(bus_rd), .bus_wr(bus_wr), .bus_data_out(bus_data_out),
        .cmd_serial_out(cmd_serial_out), .cmd_data_out(cmd_data_out)
    );

    always #2 BUS_CLK = ~BUS_CLK;

    task automatic check_byte(input string name, input cmd_byte_t actual,
                              input cmd_byte_t expected);
        if (actual !== expected) begin
            byte_errors++;
            $display("[FAIL] %0t %s: got 0x%02h, expected 0x%02h", $time, name, actual, expected);
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            bit_errors++;
            $display("[FAIL] %0t %s: got %b, expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic reset_shadow();
        foreach (shadow_regs[i])
            shadow_regs[i] = 8'h00;
        shadow_regs[5] = 8'h01;   // Repeat count defaults to 1
    endtask

    // All bus tasks start and end on a falling edge
    task automatic bus_write(input bus_addr_t addr, input cmd_byte_t data);
        bus_add     = addr;
        bus_data_in = data;
        bus_wr      = 1'b1;
        @(negedge BUS_CLK);
        bus_wr      = 1'b0;
    endtask

    task automatic bus_read(input bus_addr_t addr, output cmd_byte_t data);
        bus_add = addr;
        bus_rd  = 1'b1;
        @(negedge BUS_CLK);
        bus_rd  = 1'b0;
        data    = bus_data_out;   // Valid through the cycle after bus_rd
    endtask

    task automatic host_write(input bus_addr_t addr, input cmd_byte_t data);
        cmd_byte_t wdata;
        wdata = data;
        if (addr < 16'd16) begin
            if (addr == 16'd0)
                reset_shadow();
            else
                shadow_regs[addr[3:0]] = wdata;
        end else begin
            if (wdata == 8'hff)
                wdata = cmd_byte_t'($random(seed));   // Fill byte
            mirror[10'(addr - 16'd16)] = wdata;
        end
        bus_write(addr, wdata);
    endtask

    task automatic wait_status(input cmd_byte_t expected);
        cmd_byte_t status;
        int        polls;
        polls = 0;
        bus_read(16'd1, status);
        while (status !== expected && polls < 2000) begin
            bus_read(16'd1, status);
            polls++;
        end
        if (status !== expected) begin
            other_errors++;
            $display("Timeout at %0t: status never reached 0x%02h, last read 0x%02h",
                     $time, expected, status);
        end
    endtask

    task automatic run_stream(input int n_bytes);
        cmd_byte_t status;
        cmd_byte_t exp_byte;
        int        size;
        int        passes;
        int        n_data;
        int        i;
        int        b;
        size   = int'({shadow_regs[4], shadow_regs[3]});
        passes = int'({shadow_regs[6], shadow_regs[5]});
        if (passes == 0)
            passes = 1;   // Zero repeats still sends once
        n_data = size * passes;
        bus_write(16'd1, 8'h00);
        bus_read(16'd1, status);
        check_byte("status during run", status, 8'h00);
        @(negedge BUS_CLK);   // Third cycle after the start write
        for (i = 0; i < n_bytes; i++) begin
            if (i < n_data)
                exp_byte = mirror[i % size];
            else
                exp_byte = ((i - n_data) % 2 == 0) ? 8'h7e : 8'h81;  // Sync pair, low first
            check_byte($sformatf("cmd_data_out byte %0d", i), cmd_data_out, exp_byte);
            for (b = 0; b < 8; b++) begin
                check_bit($sformatf("cmd_serial_out byte %0d bit %0d", i, b),
                          cmd_serial_out, exp_byte[b]);
                @(negedge BUS_CLK);
            end
        end
        wait_status(8'h03);   // Done and syncing
    endtask

    task automatic soft_reset();
        host_write(16'd0, 8'h00);
        check_bit("cmd_serial_out after soft reset", cmd_serial_out, 1'b0);
        check_byte("cmd_data_out after soft reset", cmd_data_out, 8'h00);
    endtask

    initial begin
        int          fd;
        int          code;
        string       line;
        byte         op;
        logic [31:0] a;
        logic [31:0] d;
        cmd_byte_t   rd;
        BUS_CLK      = 1'b0;
        RST          = 1'b1;
        bus_add      = '0;
        bus_data_in  = '0;
        bus_rd       = 1'b0;
        bus_wr       = 1'b0;
        seed         = 62;
        byte_errors  = 0;
        bit_errors   = 0;
        other_errors = 0;
        reset_shadow();
        repeat (16) @(negedge BUS_CLK);
        RST = 1'b0;
        @(negedge BUS_CLK);

        fd = $fopen("verif/cmd_input.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("Could not open the stimulus file verif/cmd_input.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                code = $fgets(line, fd);
                if (code != 0 && line.len() > 0) begin
                    op = line.getc(0);
                    a  = '0;
                    d  = '0;
                    if (line.len() > 2)
                        code = $sscanf(line.substr(2, line.len() - 1), "%h %h", a, d);
                    case (op)
                        "W": host_write(a[15:0], d[7:0]);
                        "R": begin
                            bus_read(a[15:0], rd);
                            check_byte($sformatf("bus_data_out at 0x%04h", a[15:0]), rd, d[7:0]);
                        end
                        "S": run_stream(int'(a));
                        "Q": soft_reset();
                        default: ;   // Comment or blank line
                    endcase
                end
            end
            $fclose(fd);
        end

        $display("Errors: bus and data bytes %0d, serial bits %0d, other %0d",
                 byte_errors, bit_errors, other_errors);
        if (byte_errors + bit_errors + other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
